// ==== dv/executeStageTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module executeStageTb;
	import execPkg::*;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 10;
	localparam int numAlu = 120;
	localparam int numUnary = 40;
	localparam int numCtrlFixed = 12;
	localparam int numCtrlRandom = 40;
	localparam int numStall = 150;
	localparam int maxStallCycles = 200;
	localparam int totalInstr = 1 + numAlu + numUnary + numCtrlFixed + numCtrlRandom + numStall;
	localparam int timeoutCycles = totalInstr * 3 + maxStallCycles + resetCycles + 200;
	localparam wordT minWord = {1'b1, {(`WORD_WIDTH-1){1'b0}}};

	logic   clk;
	logic   rst;
	instrT  instrIn;
	logic   instrValid;
	logic   instrReady;
	logic   wbStall;
	resultT resultOut;
	logic   resultValid;

	logic [15:0] lfsrState = 16'd28664;
	resultT      expQ[$];
	int          errorCount = 0;
	int          resultsChecked = 0;
	int          issueCount = 0;
	int          stallCycles = 0;
	logic        lastStall = 1'b0;
	logic        lastValid = 1'b0;
	resultT      lastOut;

	executeStage DUT (
		.clk         (clk),
		.rst         (rst),
		.instrIn     (instrIn),
		.instrValid  (instrValid),
		.instrReady  (instrReady),
		.wbStall     (wbStall),
		.resultOut   (resultOut),
		.resultValid (resultValid)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// 16-bit Galois LFSR stepped once per bit handed out
	function automatic logic [63:0] randBits(input int count);
		logic [63:0] value;
		logic        outBit;
		value = '0;
		for (int i = 0; i < count; i++) begin
			outBit = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (outBit) begin
				lfsrState = lfsrState ^ 16'hB400;
			end
			value = {value[62:0], outBit};
		end
		return value;
	endfunction

	function automatic wordT edgeOperand(input int sel);
		case (sel)
			0: return '0;
			1: return '1;
			2: return minWord;
			3: return ~minWord;
			default: return randBits(64);
		endcase
	endfunction

	// Edge values show up in about half the draws
	function automatic wordT pickOperand();
		return edgeOperand(int'(randBits(3)));
	endfunction

	function automatic instrT buildInstr(input opcodeT op, input logic hasExt,
			input extOpT ext, input opLenT len);
		instrT ins;
		ins.rip = '0;
		ins.opcodeLength = len;
		ins.opcode = op;
		ins.hasExtOpcode = hasExt;
		ins.extOpcode = ext;
		ins.destReg = regCodeT'(randBits(4));
		ins.operand1 = pickOperand();
		ins.operand2 = pickOperand();
		ins.imm = pickOperand();
		ins.rflags = randBits(64);
		return ins;
	endfunction

	function automatic instrT randomAluInstr();
		logic [1:0] form;
		extOpT      digit;
		logic [2:0] low;
		opcodeT     op;
		form = 2'(randBits(2));
		digit = extOpT'(randBits(3));
		low = randBits(1) ? 3'd3 : 3'd1;
		case (form)
			2'd0: op = {2'b00, digit, low};
			2'd1: op = {2'b00, digit, 3'd5};
			2'd2: op = `OP_GRP1_IMM32;
			default: op = `OP_GRP1_IMM8;
		endcase
		return buildInstr(op, form[1], digit, 2'd1);
	endfunction

	// Expected result straight from the x86 rules
	function automatic resultT expectResult(input instrT ins);
		resultT               exp;
		aluOpT                kind;
		logic                 arithBlock;
		logic                 isCmp;
		logic                 useImm;
		logic                 setFlags;
		logic                 carry;
		extOpT                digit;
		wordT                 a;
		wordT                 b;
		wordT                 res;
		logic [`WORD_WIDTH:0] wide;
		logic                 cf;
		logic                 of;
		flagsT                f;
		kind = NOP;
		arithBlock = 1'b0;
		isCmp = 1'b0;
		useImm = 1'b0;
		digit = ins.extOpcode;
		if (ins.opcodeLength == 2'd1) begin
			// Opcodes 00-3F ending in 1, 3 or 5 are the register and accumulator forms
			if (ins.opcode[7:6] == 2'b00 && (ins.opcode[2:0] == 3'd1 ||
					ins.opcode[2:0] == 3'd3 || ins.opcode[2:0] == 3'd5)) begin
				arithBlock = 1'b1;
				digit = ins.opcode[5:3];
				useImm = (ins.opcode[2:0] == 3'd5);
			end else if ((ins.opcode == `OP_GRP1_IMM32 || ins.opcode == `OP_GRP1_IMM8) &&
					ins.hasExtOpcode) begin
				arithBlock = 1'b1;
				useImm = 1'b1;
			end else if (ins.opcode[7:3] == 5'b10111) begin
				kind = MOV_IMM;
			end else begin
				case (ins.opcode)
					`OP_MOV_RM, `OP_MOV_MR: kind = MOV_OP2;
					`OP_MOV_IMM32: begin
						if (ins.hasExtOpcode && ins.extOpcode == 3'd0) kind = MOV_IMM;
					end
					`OP_GRP3: begin
						if (ins.hasExtOpcode && ins.extOpcode == 3'd2) kind = NOT;
						if (ins.hasExtOpcode && ins.extOpcode == 3'd3) kind = NEG;
					end
					`OP_GRP5: begin
						if (ins.hasExtOpcode && ins.extOpcode == 3'd0) kind = INC;
						if (ins.hasExtOpcode && ins.extOpcode == 3'd1) kind = DEC;
					end
					`OP_RET_NEAR, `OP_RET_FAR, `OP_IRET: kind = KILL;
					default: kind = NOP;
				endcase
			end
		end
		if (arithBlock) begin
			case (digit)
				3'd0: kind = ADD;
				3'd1: kind = OR;
				3'd2: kind = ADC;
				3'd3: kind = SBB;
				3'd4: kind = AND;
				3'd5: kind = SUB;
				3'd6: kind = XOR;
				default: begin
					kind = SUB;
					isCmp = 1'b1;
				end
			endcase
		end

		a = ins.operand1;
		b = useImm ? ins.imm : ins.operand2;
		carry = (kind == ADC || kind == SBB) ? ins.rflags[`CF_BIT] : 1'b0;
		f = ins.rflags;
		cf = f[`CF_BIT];
		of = f[`OF_BIT];
		res = '0;
		setFlags = 1'b1;
		case (kind)
			MOV_OP2: res = ins.operand2;
			MOV_IMM: res = ins.imm;
			NOT: res = ~a;
			OR, AND, XOR: begin
				res = (kind == OR) ? (a | b) : (kind == AND) ? (a & b) : (a ^ b);
				cf = 1'b0;
				of = 1'b0;
			end
			ADD, ADC: begin
				wide = {1'b0, a} + {1'b0, b} + {{`WORD_WIDTH{1'b0}}, carry};
				res = wide[`WORD_WIDTH-1:0];
				cf = wide[`WORD_WIDTH];
				of = (a[63] == b[63]) && (res[63] != a[63]);
			end
			SUB, SBB: begin
				wide = {1'b0, a} - {1'b0, b} - {{`WORD_WIDTH{1'b0}}, carry};
				res = wide[`WORD_WIDTH-1:0];
				cf = wide[`WORD_WIDTH];
				of = (a[63] != b[63]) && (res[63] != a[63]);
			end
			INC: begin
				res = a + wordT'(1);
				of = !a[63] && res[63];
			end
			DEC: begin
				res = a - wordT'(1);
				of = a[63] && !res[63];
			end
			NEG: begin
				res = wordT'(0) - a;
				cf = (a != '0);
				of = (a == minWord);
			end
			default: res = '0;
		endcase
		if (kind == MOV_OP2 || kind == MOV_IMM || kind == NOT ||
				kind == NOP || kind == KILL) begin
			setFlags = 1'b0;
		end
		if (setFlags) begin
			f[`CF_BIT] = cf;
			f[`OF_BIT] = of;
			f[`ZF_BIT] = (res == '0);
			f[`SF_BIT] = res[63];
			f[`PF_BIT] = ~^res[7:0];
		end

		exp.rip = ins.rip;
		exp.destReg = ins.destReg;
		exp.aluResult = res;
		exp.rflags = f;
		exp.kill = (kind == KILL);
		exp.writeDest = (arithBlock && !isCmp) || kind == MOV_OP2 || kind == MOV_IMM ||
			kind == NOT || kind == NEG || kind == INC || kind == DEC;
		exp.executeOk = arithBlock || exp.writeDest || exp.kill ||
			(ins.opcodeLength == 2'd1 && ins.opcode == `OP_NOP);
		return exp;
	endfunction

	task automatic reportValue(input string name, input logic [63:0] expVal,
			input logic [63:0] gotVal);
		errorCount++;
		$display("[ERROR] %s: expected 0x%h, got 0x%h", name, expVal, gotVal);
	endtask

	task automatic compareResult(input resultT got, input resultT exp);
		if (got.rip !== exp.rip) reportValue("rip", exp.rip, got.rip);
		if (got.destReg !== exp.destReg) reportValue("destReg", exp.destReg, got.destReg);
		if (got.executeOk !== exp.executeOk) reportValue("executeOk", exp.executeOk, got.executeOk);
		if (got.writeDest !== exp.writeDest) reportValue("writeDest", exp.writeDest, got.writeDest);
		if (got.kill !== exp.kill) reportValue("kill", exp.kill, got.kill);
		if (got.rflags !== exp.rflags) reportValue("rflags", exp.rflags, got.rflags);
		// Result only matters where it is written back
		if (exp.writeDest && got.aluResult !== exp.aluResult) begin
			reportValue("aluResult", exp.aluResult, got.aluResult);
		end
	endtask

	// Holds the instruction until a cycle with wbStall low takes it
	task automatic issue(input instrT ins, input logic withStall);
		logic stallNow;
		ins.rip = ripT'(issueCount);
		issueCount++;
		instrIn = ins;
		instrValid = 1'b1;
		do begin
			stallNow = withStall && (randBits(2) == 0) && (stallCycles < maxStallCycles);
			if (stallNow) stallCycles++;
			wbStall = stallNow;
			@(posedge clk);
			#1;
		end while (stallNow);
	endtask

	task automatic drain();
		instrValid = 1'b0;
		wbStall = 1'b0;
		while (expQ.size() != 0) @(posedge clk);
		#1;
	endtask

	task automatic finishTest(input string name, input int errStart, input int chkStart);
		$display("Test %s: %0d results checked, %0d errors", name,
			resultsChecked - chkStart, errorCount - errStart);
	endtask

	always @(posedge clk) begin : resultCheck
		resultT expected;
		if (!rst) begin
			if (instrReady !== !wbStall) reportValue("instrReady", !wbStall, instrReady);
			if (lastStall && (resultValid !== lastValid || resultOut !== lastOut)) begin
				errorCount++;
				$display("Result output changed while the write-back stall was high");
			end
			if (instrValid && instrReady) expQ.push_back(expectResult(instrIn));
			if (resultValid && !wbStall) begin
				if (expQ.size() == 0) begin
					errorCount++;
					$display("A result arrived with no instruction outstanding");
				end else begin
					expected = expQ.pop_front();
					compareResult(resultOut, expected);
					resultsChecked++;
				end
			end
		end
		lastStall = wbStall;
		lastValid = resultValid;
		lastOut = resultOut;
	end

	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Watchdog expired, %0d results did not arrive", expQ.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		instrT ins;
		wordT  edgeVal;
		int    errStart;
		int    chkStart;

		rst = 1'b1;
		instrValid = 1'b0;
		wbStall = 1'b0;
		instrIn = '0;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;

		// Reset state and the three-stage latency
		errStart = errorCount;
		chkStart = resultsChecked;
		if (resultValid !== 1'b0) reportValue("resultValid", 0, resultValid);
		if (resultOut.executeOk !== 1'b0) reportValue("executeOk", 0, resultOut.executeOk);
		if (resultOut.writeDest !== 1'b0) reportValue("writeDest", 0, resultOut.writeDest);
		if (resultOut.kill !== 1'b0) reportValue("kill", 0, resultOut.kill);
		issue(buildInstr(`OP_ADD_RM, 1'b0, 3'd0, 2'd1), 1'b0);
		instrValid = 1'b0;
		// Decode loads at the accepting edge, the result two edges later
		for (int k = 1; k <= 3; k++) begin
			@(posedge clk);
			#1;
			if (resultValid !== (k == 2)) reportValue("resultValid", (k == 2), resultValid);
		end
		drain();
		finishTest("reset latency", errStart, chkStart);

		errStart = errorCount;
		chkStart = resultsChecked;
		for (int n = 0; n < numAlu; n++) begin
			issue(randomAluInstr(), 1'b0);
		end
		drain();
		finishTest("alu forms", errStart, chkStart);

		// Each unary and MOV form against every edge operand
		errStart = errorCount;
		chkStart = resultsChecked;
		for (int e = 0; e < 5; e++) begin
			for (int k = 0; k < 8; k++) begin
				edgeVal = edgeOperand(e);
				case (k)
					0: ins = buildInstr(`OP_GRP5, 1'b1, `EXT_INC, 2'd1);
					1: ins = buildInstr(`OP_GRP5, 1'b1, `EXT_DEC, 2'd1);
					2: ins = buildInstr(`OP_GRP3, 1'b1, `EXT_NEG, 2'd1);
					3: ins = buildInstr(`OP_GRP3, 1'b1, `EXT_NOT, 2'd1);
					4: ins = buildInstr(`OP_MOV_RM, 1'b0, 3'd0, 2'd1);
					5: ins = buildInstr(`OP_MOV_MR, 1'b0, 3'd0, 2'd1);
					6: begin
						ins = buildInstr(`OP_MOV_IMM_BASE | opcodeT'(randBits(3)),
							1'b0, 3'd0, 2'd1);
					end
					default: ins = buildInstr(`OP_MOV_IMM32, 1'b1, `EXT_MOV, 2'd1);
				endcase
				if (k < 4) ins.operand1 = edgeVal;
				else if (k < 6) ins.operand2 = edgeVal;
				else ins.imm = edgeVal;
				issue(ins, 1'b0);
			end
		end
		drain();
		finishTest("unary and mov", errStart, chkStart);

		errStart = errorCount;
		chkStart = resultsChecked;
		issue(buildInstr(`OP_NOP, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(`OP_RET_NEAR, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(`OP_RET_FAR, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(`OP_IRET, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(8'h00, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(8'h0F, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(`OP_GRP3, 1'b1, 3'd4, 2'd1), 1'b0);
		issue(buildInstr(`OP_GRP5, 1'b1, 3'd2, 2'd1), 1'b0);
		issue(buildInstr(`OP_GRP1_IMM32, 1'b0, 3'd0, 2'd1), 1'b0);
		issue(buildInstr(`OP_MOV_IMM32, 1'b1, 3'd1, 2'd1), 1'b0);
		issue(buildInstr(`OP_ADD_RM, 1'b0, 3'd0, 2'd2), 1'b0);
		issue(buildInstr(`OP_NOP, 1'b0, 3'd0, 2'd0), 1'b0);
		for (int n = 0; n < numCtrlRandom; n++) begin
			issue(buildInstr(opcodeT'(randBits(8)), randBits(1) != 0, extOpT'(randBits(3)),
				opLenT'(randBits(2))), 1'b0);
		end
		drain();
		finishTest("control and unknown", errStart, chkStart);

		errStart = errorCount;
		chkStart = resultsChecked;
		for (int n = 0; n < numStall; n++) begin
			if (randBits(1) != 0) ins = randomAluInstr();
			else ins = buildInstr(opcodeT'(randBits(8)), 1'b1, extOpT'(randBits(3)), 2'd1);
			issue(ins, 1'b1);
		end
		drain();
		finishTest("stall stress", errStart, chkStart);

		if (resultsChecked != issueCount) begin
			errorCount++;
			$display("Results checked do not match the number of issued instructions");
		end
		$display("Summary: %0d issued, %0d results checked, %0d stall cycles, %0d errors",
			issueCount, resultsChecked, stallCycles, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/execPkg.sv
verilog/instrDecode.sv
verilog/aluExecute.sv
verilog/flagResult.sv
verilog/executeStage.sv
dv/executeStageTb.sv

// ==== verilog/aluExecute.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module aluExecute (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  execPkg::decodedT decIn,
	input  logic             decValid,
	output execPkg::aluOutT  aluOut,
	output logic             exeValid
);
	import execPkg::*;

	wordT                addA;
	wordT                addB;
	wordT                addBEff;
	logic                subtract;
	logic                addCarry;
	logic [`WORD_WIDTH:0] sum;
	wordT                result;
	logic                carryOut;
	logic                overflow;
	aluOutT              aluNext;

	// Adder operand setup, subtraction as A + ~B + 1
	always_comb begin
		addA = decIn.operand1;
		addB = decIn.operandB;
		subtract = 1'b0;
		addCarry = 1'b0;
		case (decIn.aluOp)
			ADC: addCarry = decIn.carryIn;
			SUB: begin
				subtract = 1'b1;
				addCarry = 1'b1;
			end
			SBB: begin
				subtract = 1'b1;
				addCarry = ~decIn.carryIn;
			end
			INC: addB = wordT'(1);
			DEC: begin
				addB = wordT'(1);
				subtract = 1'b1;
				addCarry = 1'b1;
			end
			NEG: begin
				addA = '0;
				addB = decIn.operand1;
				subtract = 1'b1;
				addCarry = 1'b1;
			end
			default: addCarry = 1'b0;
		endcase
	end

	assign addBEff = addB ^ {`WORD_WIDTH{subtract}};
	assign sum = {1'b0, addA} + {1'b0, addBEff} + {{`WORD_WIDTH{1'b0}}, addCarry};

	// Borrow is the inverted carry on subtraction
	assign carryOut = sum[`WORD_WIDTH] ^ subtract;
	assign overflow = (addA[`WORD_WIDTH-1] == addBEff[`WORD_WIDTH-1]) &&
		(sum[`WORD_WIDTH-1] != addA[`WORD_WIDTH-1]);

	always_comb begin
		case (decIn.aluOp)
			MOV_OP2, MOV_IMM: result = decIn.operandB;
			OR: result = decIn.operand1 | decIn.operandB;
			AND: result = decIn.operand1 & decIn.operandB;
			XOR: result = decIn.operand1 ^ decIn.operandB;
			NOT: result = ~decIn.operand1;
			ADD, ADC, SUB, SBB, INC, DEC, NEG: result = sum[`WORD_WIDTH-1:0];
			default: result = '0;
		endcase
	end

	always_comb begin
		aluNext.flagPolicy = decIn.flagPolicy;
		aluNext.writeDest = decIn.writeDest;
		aluNext.executeOk = decIn.executeOk;
		aluNext.kill = decIn.kill;
		aluNext.rip = decIn.rip;
		aluNext.destReg = decIn.destReg;
		aluNext.rflags = decIn.rflags;
		aluNext.operand1 = decIn.operand1;
		aluNext.aluResult = result;
		aluNext.carryOut = carryOut;
		aluNext.overflow = overflow;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exeValid <= 1'b0;
			aluOut.writeDest <= 1'b0;
			aluOut.executeOk <= 1'b0;
			aluOut.kill <= 1'b0;
		end else if (!stall) begin
			exeValid <= decValid;
			aluOut <= aluNext;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/execPkg.sv ====
`default_nettype none

`include "exec_macros.svh"

package execPkg;

	typedef logic [`WORD_WIDTH-1:0]  wordT;
	typedef logic [`FLAGS_WIDTH-1:0] flagsT;
	typedef logic [`WORD_WIDTH-1:0]  ripT;
	typedef logic [7:0]              opcodeT;
	typedef logic [2:0]              extOpT;
	typedef logic [1:0]              opLenT;
	typedef logic [3:0]              regCodeT;

	// CMP decodes to SUB with the destination write suppressed
	typedef enum logic [3:0] {
		MOV_OP2, MOV_IMM, OR, AND, XOR, ADD, ADC, SUB,
		SBB, NEG, NOT, INC, DEC, NOP, KILL
	} aluOpT;

	typedef enum logic [2:0] {
		FLAG_KEEP, FLAG_LOGIC, FLAG_ARITH, FLAG_INCDEC, FLAG_NEG
	} flagPolicyT;

	typedef struct packed {
		ripT     rip;
		opLenT   opcodeLength;
		opcodeT  opcode;
		logic    hasExtOpcode;
		extOpT   extOpcode;
		regCodeT destReg;
		wordT    operand1;
		wordT    operand2;
		wordT    imm;
		flagsT   rflags;
	} instrT;

	typedef struct packed {
		aluOpT      aluOp;
		flagPolicyT flagPolicy;
		logic       writeDest;
		logic       executeOk;
		logic       kill;
		wordT       operand1;
		wordT       operandB;
		logic       carryIn;
		ripT        rip;
		regCodeT    destReg;
		flagsT      rflags;
	} decodedT;

	typedef struct packed {
		flagPolicyT flagPolicy;
		logic       writeDest;
		logic       executeOk;
		logic       kill;
		ripT        rip;
		regCodeT    destReg;
		flagsT      rflags;
		wordT       operand1;
		wordT       aluResult;
		logic       carryOut;
		logic       overflow;
	} aluOutT;

	typedef struct packed {
		ripT     rip;
		regCodeT destReg;
		wordT    aluResult;
		logic    writeDest;
		flagsT   rflags;
		logic    executeOk;
		logic    kill;
	} resultT;

endpackage

`default_nettype wire

// ==== verilog/exec_macros.svh ====
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Datapath widths
`define WORD_WIDTH  64
`define FLAGS_WIDTH 64

// RFLAGS bit positions
`define CF_BIT 0
`define PF_BIT 2
`define ZF_BIT 6
`define SF_BIT 7
`define OF_BIT 11

// Single-byte opcodes outside the ALU block
`define OP_NOP          8'h90
`define OP_MOV_RM       8'h89
`define OP_MOV_MR       8'h8B
`define OP_MOV_IMM_BASE 8'hB8
`define OP_MOV_IMM_MASK 8'hF8
`define OP_MOV_IMM32    8'hC7
`define OP_GRP1_IMM32   8'h81
`define OP_GRP1_IMM8    8'h83
`define OP_GRP3         8'hF7
`define OP_GRP5         8'hFF
`define OP_RET_NEAR     8'hC3
`define OP_RET_FAR      8'hCB
`define OP_IRET         8'hCF

// ALU block, r/m,reg then reg,r/m then accumulator,imm
`define OP_ADD_RM  8'h01
`define OP_ADD_MR  8'h03
`define OP_ADD_ACC 8'h05
`define OP_OR_RM   8'h09
`define OP_OR_MR   8'h0B
`define OP_OR_ACC  8'h0D
`define OP_ADC_RM  8'h11
`define OP_ADC_MR  8'h13
`define OP_ADC_ACC 8'h15
`define OP_SBB_RM  8'h19
`define OP_SBB_MR  8'h1B
`define OP_SBB_ACC 8'h1D
`define OP_AND_RM  8'h21
`define OP_AND_MR  8'h23
`define OP_AND_ACC 8'h25
`define OP_SUB_RM  8'h29
`define OP_SUB_MR  8'h2B
`define OP_SUB_ACC 8'h2D
`define OP_XOR_RM  8'h31
`define OP_XOR_MR  8'h33
`define OP_XOR_ACC 8'h35
`define OP_CMP_RM  8'h39
`define OP_CMP_MR  8'h3B
`define OP_CMP_ACC 8'h3D

// ModRM reg-field digits, group 1
`define EXT_ADD 3'd0
`define EXT_OR  3'd1
`define EXT_ADC 3'd2
`define EXT_SBB 3'd3
`define EXT_AND 3'd4
`define EXT_SUB 3'd5
`define EXT_XOR 3'd6
`define EXT_CMP 3'd7

// Digits for C7, F7 and FF
`define EXT_MOV 3'd0
`define EXT_NOT 3'd2
`define EXT_NEG 3'd3
`define EXT_INC 3'd0
`define EXT_DEC 3'd1

`endif

// ==== verilog/executeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeStage (
	input  logic            clk,
	input  logic            rst,
	input  execPkg::instrT  instrIn,
	input  logic            instrValid,
	output logic            instrReady,
	input  logic            wbStall,
	output execPkg::resultT resultOut,
	output logic            resultValid
);
	import execPkg::*;

	decodedT decBus;
	logic    decValid;
	aluOutT  aluBus;
	logic    exeValid;

	// Write-back stall freezes all three stages at once
	assign instrReady = ~wbStall;

	instrDecode decodeStage (
		.clk        (clk),
		.rst        (rst),
		.stall      (wbStall),
		.instrIn    (instrIn),
		.instrValid (instrValid),
		.decOut     (decBus),
		.decValid   (decValid)
	);

	aluExecute aluStage (
		.clk      (clk),
		.rst      (rst),
		.stall    (wbStall),
		.decIn    (decBus),
		.decValid (decValid),
		.aluOut   (aluBus),
		.exeValid (exeValid)
	);

	flagResult flagStage (
		.clk         (clk),
		.rst         (rst),
		.stall       (wbStall),
		.aluIn       (aluBus),
		.exeValid    (exeValid),
		.resultOut   (resultOut),
		.resultValid (resultValid)
	);

endmodule

`default_nettype wire

// ==== verilog/flagResult.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module flagResult (
	input  logic            clk,
	input  logic            rst,
	input  logic            stall,
	input  execPkg::aluOutT aluIn,
	input  logic            exeValid,
	output execPkg::resultT resultOut,
	output logic            resultValid
);
	import execPkg::*;

	localparam wordT minWord = {1'b1, {(`WORD_WIDTH-1){1'b0}}};

	logic   zf;
	logic   sf;
	logic   pf;
	flagsT  flagsNext;
	resultT resNext;

	assign zf = (aluIn.aluResult == '0);
	assign sf = aluIn.aluResult[`WORD_WIDTH-1];
	// Even parity over the low byte only
	assign pf = ~^aluIn.aluResult[7:0];

	always_comb begin
		flagsNext = aluIn.rflags;
		if (aluIn.flagPolicy != FLAG_KEEP) begin
			flagsNext[`ZF_BIT] = zf;
			flagsNext[`SF_BIT] = sf;
			flagsNext[`PF_BIT] = pf;
		end
		case (aluIn.flagPolicy)
			FLAG_LOGIC: begin
				flagsNext[`CF_BIT] = 1'b0;
				flagsNext[`OF_BIT] = 1'b0;
			end
			FLAG_ARITH: begin
				flagsNext[`CF_BIT] = aluIn.carryOut;
				flagsNext[`OF_BIT] = aluIn.overflow;
			end
			// CF survives INC and DEC
			FLAG_INCDEC: flagsNext[`OF_BIT] = aluIn.overflow;
			FLAG_NEG: begin
				flagsNext[`CF_BIT] = (aluIn.operand1 != '0);
				flagsNext[`OF_BIT] = (aluIn.operand1 == minWord);
			end
			default: flagsNext = aluIn.rflags;
		endcase
	end

	always_comb begin
		resNext.rip = aluIn.rip;
		resNext.destReg = aluIn.destReg;
		resNext.aluResult = aluIn.aluResult;
		resNext.writeDest = aluIn.writeDest;
		resNext.rflags = flagsNext;
		resNext.executeOk = aluIn.executeOk;
		resNext.kill = aluIn.kill;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid <= 1'b0;
			resultOut.writeDest <= 1'b0;
			resultOut.executeOk <= 1'b0;
			resultOut.kill <= 1'b0;
		end else if (!stall) begin
			resultValid <= exeValid;
			resultOut <= resNext;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/instrDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_macros.svh"

module instrDecode (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  execPkg::instrT   instrIn,
	input  logic             instrValid,
	output execPkg::decodedT decOut,
	output logic             decValid
);
	import execPkg::*;

	logic       aluForm;
	logic       aluImm;
	extOpT      aluDigit;
	aluOpT      aluOpNext;
	flagPolicyT policyNext;
	logic       writeNext;
	logic       okNext;
	logic       killNext;
	logic       useImm;
	decodedT    decNext;

	// Register and accumulator forms reuse the group 1 digit numbering
	always_comb begin
		aluForm = 1'b1;
		aluDigit = instrIn.extOpcode;
		case (instrIn.opcode)
			`OP_ADD_RM, `OP_ADD_MR, `OP_ADD_ACC: aluDigit = `EXT_ADD;
			`OP_OR_RM, `OP_OR_MR, `OP_OR_ACC: aluDigit = `EXT_OR;
			`OP_ADC_RM, `OP_ADC_MR, `OP_ADC_ACC: aluDigit = `EXT_ADC;
			`OP_SBB_RM, `OP_SBB_MR, `OP_SBB_ACC: aluDigit = `EXT_SBB;
			`OP_AND_RM, `OP_AND_MR, `OP_AND_ACC: aluDigit = `EXT_AND;
			`OP_SUB_RM, `OP_SUB_MR, `OP_SUB_ACC: aluDigit = `EXT_SUB;
			`OP_XOR_RM, `OP_XOR_MR, `OP_XOR_ACC: aluDigit = `EXT_XOR;
			`OP_CMP_RM, `OP_CMP_MR, `OP_CMP_ACC: aluDigit = `EXT_CMP;
			`OP_GRP1_IMM32, `OP_GRP1_IMM8: aluForm = instrIn.hasExtOpcode;
			default: aluForm = 1'b0;
		endcase

		case (instrIn.opcode)
			`OP_ADD_ACC, `OP_OR_ACC, `OP_ADC_ACC, `OP_SBB_ACC,
			`OP_AND_ACC, `OP_SUB_ACC, `OP_XOR_ACC, `OP_CMP_ACC,
			`OP_GRP1_IMM32, `OP_GRP1_IMM8: aluImm = 1'b1;
			default: aluImm = 1'b0;
		endcase
	end

	always_comb begin
		aluOpNext = NOP;
		policyNext = FLAG_KEEP;
		writeNext = 1'b0;
		okNext = 1'b0;
		killNext = 1'b0;
		useImm = 1'b0;
		if (instrIn.opcodeLength == 2'd1) begin
			if (aluForm) begin
				okNext = 1'b1;
				writeNext = (aluDigit != `EXT_CMP);
				useImm = aluImm;
				case (aluDigit)
					`EXT_ADD: aluOpNext = ADD;
					`EXT_OR: aluOpNext = OR;
					`EXT_ADC: aluOpNext = ADC;
					`EXT_SBB: aluOpNext = SBB;
					`EXT_AND: aluOpNext = AND;
					`EXT_XOR: aluOpNext = XOR;
					default: aluOpNext = SUB;
				endcase
				policyNext = (aluOpNext inside {OR, AND, XOR}) ? FLAG_LOGIC : FLAG_ARITH;
			end else begin
				case (instrIn.opcode)
					`OP_MOV_RM, `OP_MOV_MR: aluOpNext = MOV_OP2;
					`OP_MOV_IMM32: begin
						if (instrIn.hasExtOpcode && instrIn.extOpcode == `EXT_MOV) begin
							aluOpNext = MOV_IMM;
						end
					end
					`OP_GRP3: begin
						if (instrIn.hasExtOpcode && instrIn.extOpcode == `EXT_NOT) begin
							aluOpNext = NOT;
						end else if (instrIn.hasExtOpcode && instrIn.extOpcode == `EXT_NEG) begin
							aluOpNext = NEG;
						end
					end
					`OP_GRP5: begin
						if (instrIn.hasExtOpcode && instrIn.extOpcode == `EXT_INC) begin
							aluOpNext = INC;
						end else if (instrIn.hasExtOpcode && instrIn.extOpcode == `EXT_DEC) begin
							aluOpNext = DEC;
						end
					end
					`OP_RET_NEAR, `OP_RET_FAR, `OP_IRET: aluOpNext = KILL;
					default: begin
						// B8-BF carry the register in the low three bits
						if ((instrIn.opcode & `OP_MOV_IMM_MASK) == `OP_MOV_IMM_BASE) begin
							aluOpNext = MOV_IMM;
						end
					end
				endcase
				killNext = (aluOpNext == KILL);
				useImm = (aluOpNext == MOV_IMM);
				writeNext = aluOpNext inside {MOV_OP2, MOV_IMM, NOT, NEG, INC, DEC};
				okNext = writeNext || killNext || (instrIn.opcode == `OP_NOP);
				if (aluOpNext inside {INC, DEC}) begin
					policyNext = FLAG_INCDEC;
				end else if (aluOpNext == NEG) begin
					policyNext = FLAG_NEG;
				end
			end
		end
	end

	always_comb begin
		decNext.aluOp = aluOpNext;
		decNext.flagPolicy = policyNext;
		decNext.writeDest = writeNext;
		decNext.executeOk = okNext;
		decNext.kill = killNext;
		decNext.operand1 = instrIn.operand1;
		decNext.operandB = useImm ? instrIn.imm : instrIn.operand2;
		decNext.carryIn = (aluOpNext inside {ADC, SBB}) ? instrIn.rflags[`CF_BIT] : 1'b0;
		decNext.rip = instrIn.rip;
		decNext.destReg = instrIn.destReg;
		decNext.rflags = instrIn.rflags;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			decValid <= 1'b0;
			decOut.writeDest <= 1'b0;
			decOut.executeOk <= 1'b0;
			decOut.kill <= 1'b0;
		end else if (!stall) begin
			decValid <= instrValid;
			decOut <= decNext;
		end
	end

endmodule

`default_nettype wire
